//--- hdl/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [10:0] dist_t;        // manhattan distance, one bit above a coordinate
    typedef logic [2:0]  meteor_size_t;
    typedef logic [2:0]  hp_t;
    typedef logic [15:0] score_t;
    typedef logic [7:0]  points_t;
    typedef logic [7:0]  frame_count_t;

    typedef enum logic [1:0] {
        FACE_UP    = 2'd0,
        FACE_RIGHT = 2'd1,
        FACE_DOWN  = 2'd2,
        FACE_LEFT  = 2'd3
    } facing_t;

    typedef enum logic {
        STATE_PLAYING = 1'b0,
        STATE_OVER    = 1'b1
    } play_state_t;

    typedef struct packed {
        coord_t       x;
        coord_t       y;
        meteor_size_t size;
    } meteor_t;

    // one frame's worth of button request
    typedef struct packed {
        logic    move;
        facing_t dir;
        logic    fire;
    } move_cmd_t;

    localparam int     SCREEN_W        = 640;
    localparam int     SCREEN_H        = 480;
    localparam coord_t SHIP_SPEED      = 10'd2;
    localparam coord_t BULLET_SPEED    = 10'd10;
    localparam hp_t    SHIP_MAX_HP     = 3'd4;
    localparam coord_t SHIP_COLL_R     = 10'd10;
    localparam hp_t    METEOR_START_HP = 3'd3;

    // sizes of 4 and above share the largest radius
    function automatic coord_t meteor_radius(input meteor_size_t size);
        case (size)
            3'd0:    return 10'd4;
            3'd1:    return 10'd8;
            3'd2:    return 10'd12;
            3'd3:    return 10'd16;
            default: return 10'd20;
        endcase
    endfunction

    function automatic points_t meteor_points(input meteor_size_t size);
        case (size)
            3'd0:    return 8'd10;
            3'd1:    return 8'd20;
            3'd2:    return 8'd30;
            3'd3:    return 8'd40;
            default: return 8'd50;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hdl/input_decode.sv
`timescale 1ns/100ps
`default_nettype none

module input_decode (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                frame_tick,
    input  logic                btn_up,
    input  logic                btn_down,
    input  logic                btn_left,
    input  logic                btn_right,
    input  logic                btn_fire,
    input  logic                btn_restart,
    input  logic                hull_depleted,
    output logic                play_tick,
    output logic                restart,
    output game_pkg::move_cmd_t cmd,
    output logic                game_over
);

    game_pkg::play_state_t state;

    assign play_tick = frame_tick && (state == game_pkg::STATE_PLAYING);
    assign restart   = frame_tick && (state == game_pkg::STATE_OVER) && btn_restart;
    assign game_over = (state == game_pkg::STATE_OVER);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= game_pkg::STATE_PLAYING;
        end else if (frame_tick) begin
            case (state)
                game_pkg::STATE_PLAYING: begin
                    if (hull_depleted)
                        state <= game_pkg::STATE_OVER;
                end
                default: begin
                    if (restart)
                        state <= game_pkg::STATE_PLAYING;
                end
            endcase
        end
    end

    // up wins over down, down over right, right over left
    always_comb begin
        cmd.move = btn_up || btn_down || btn_right || btn_left;
        cmd.fire = btn_fire;
        cmd.dir  = game_pkg::FACE_UP;
        if (btn_down && !btn_up)
            cmd.dir = game_pkg::FACE_DOWN;
        else if (btn_right && !btn_up && !btn_down)
            cmd.dir = game_pkg::FACE_RIGHT;
        else if (btn_left && !btn_up && !btn_down && !btn_right)
            cmd.dir = game_pkg::FACE_LEFT;
    end

    // the hull can only run out on a frame that is being played
    assert property (@(posedge clk) disable iff (!reset_n) hull_depleted |-> play_tick)
        else $error("hull_depleted outside a playing frame");

endmodule

`default_nettype wire

//--- hdl/ship_bullet_motion.sv
`timescale 1ns/100ps
`default_nettype none

module ship_bullet_motion #(
    parameter int FIRE_COOLDOWN = 30
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                frame_tick,
    input  logic                play_tick,
    input  logic                restart,
    input  game_pkg::move_cmd_t cmd,
    input  logic                bullet_hit,
    output game_pkg::coord_t    ship_x,
    output game_pkg::coord_t    ship_y,
    output game_pkg::facing_t   ship_facing,
    output game_pkg::coord_t    bullet_x,
    output game_pkg::coord_t    bullet_y,
    output logic                bullet_active
);

    localparam game_pkg::coord_t START_X = game_pkg::coord_t'(game_pkg::SCREEN_W / 2);
    localparam game_pkg::coord_t START_Y = game_pkg::coord_t'(game_pkg::SCREEN_H / 2);
    localparam game_pkg::coord_t MAX_X   = game_pkg::coord_t'(game_pkg::SCREEN_W - 1);
    localparam game_pkg::coord_t MAX_Y   = game_pkg::coord_t'(game_pkg::SCREEN_H - 1);

    game_pkg::frame_count_t cooldown;
    game_pkg::coord_t       ship_x_nxt;
    game_pkg::coord_t       ship_y_nxt;
    logic                   launch;

    // one step with clamping at the screen edges
    always_comb begin
        ship_x_nxt = ship_x;
        ship_y_nxt = ship_y;
        if (cmd.move) begin
            case (cmd.dir)
                game_pkg::FACE_UP:
                    ship_y_nxt = (ship_y > game_pkg::SHIP_SPEED) ?
                                 ship_y - game_pkg::SHIP_SPEED : '0;
                game_pkg::FACE_DOWN:
                    ship_y_nxt = (ship_y < MAX_Y - game_pkg::SHIP_SPEED) ?
                                 ship_y + game_pkg::SHIP_SPEED : MAX_Y;
                game_pkg::FACE_RIGHT:
                    ship_x_nxt = (ship_x < MAX_X - game_pkg::SHIP_SPEED) ?
                                 ship_x + game_pkg::SHIP_SPEED : MAX_X;
                default:
                    ship_x_nxt = (ship_x > game_pkg::SHIP_SPEED) ?
                                 ship_x - game_pkg::SHIP_SPEED : '0;
            endcase
        end
    end

    assign launch = cmd.fire && !bullet_active && (cooldown == '0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ship_x        <= START_X;
            ship_y        <= START_Y;
            ship_facing   <= game_pkg::FACE_UP;
            bullet_x      <= '0;
            bullet_y      <= '0;
            bullet_active <= 1'b0;
            cooldown      <= '0;
        end else if (restart) begin
            ship_x        <= START_X;
            ship_y        <= START_Y;
            ship_facing   <= game_pkg::FACE_UP;
            bullet_x      <= '0;
            bullet_y      <= '0;
            bullet_active <= 1'b0;
            cooldown      <= '0;
        end else if (frame_tick) begin
            if (cooldown != '0)
                cooldown <= cooldown - 1'b1;   // keeps running after game over too
            if (play_tick) begin
                ship_x <= ship_x_nxt;
                ship_y <= ship_y_nxt;
                if (cmd.move)
                    ship_facing <= cmd.dir;
                if (launch) begin
                    bullet_active <= 1'b1;
                    bullet_x      <= ship_x;   // launched from where the ship was
                    bullet_y      <= ship_y;
                    cooldown      <= game_pkg::frame_count_t'(FIRE_COOLDOWN);
                end else if (bullet_active) begin
                    if (bullet_y > game_pkg::BULLET_SPEED) begin
                        bullet_y <= bullet_y - game_pkg::BULLET_SPEED;
                    end else begin
                        bullet_y      <= '0;
                        bullet_active <= 1'b0;
                    end
                    if (bullet_hit)
                        bullet_active <= 1'b0;
                end
            end
        end
    end

    // no new bullet appears while the cooldown is still running
    assert property (@(posedge clk) disable iff (!reset_n)
        play_tick && !bullet_active && (cooldown != '0) |=> !bullet_active)
        else $error("bullet launched during fire cooldown");

endmodule

`default_nettype wire

//--- hdl/meteor_hit_check.sv
`timescale 1ns/100ps
`default_nettype none

module meteor_hit_check #(
    parameter int NUM_METEORS = 5
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   play_tick,
    input  logic                   restart,
    input  game_pkg::meteor_t      meteors [NUM_METEORS],
    input  game_pkg::coord_t       ship_x,
    input  game_pkg::coord_t       ship_y,
    input  game_pkg::coord_t       bullet_x,
    input  game_pkg::coord_t       bullet_y,
    input  logic                   bullet_active,
    output logic [NUM_METEORS-1:0] meteor_alive,
    output logic                   bullet_hit,
    output logic                   ship_contact,
    output game_pkg::points_t      kill_points
);

    game_pkg::hp_t          health [NUM_METEORS];
    logic [NUM_METEORS-1:0] hit_vec;
    logic [NUM_METEORS-1:0] hit_sel;
    logic [NUM_METEORS-1:0] contact_vec;

    function automatic game_pkg::coord_t abs_diff(input game_pkg::coord_t a,
                                                  input game_pkg::coord_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    for (genvar i = 0; i < NUM_METEORS; i++) begin : g_meteor
        game_pkg::coord_t radius;
        game_pkg::dist_t  bullet_dist;
        game_pkg::dist_t  ship_dist;
        game_pkg::dist_t  contact_r;

        assign radius      = game_pkg::meteor_radius(meteors[i].size);
        assign bullet_dist = {1'b0, abs_diff(bullet_x, meteors[i].x)} +
                             {1'b0, abs_diff(bullet_y, meteors[i].y)};
        assign ship_dist   = {1'b0, abs_diff(ship_x, meteors[i].x)} +
                             {1'b0, abs_diff(ship_y, meteors[i].y)};
        assign contact_r   = {1'b0, game_pkg::SHIP_COLL_R} + {1'b0, radius};

        assign hit_vec[i]     = bullet_active && meteor_alive[i] &&
                                (bullet_dist <= {1'b0, radius});
        assign contact_vec[i] = meteor_alive[i] && (ship_dist <= contact_r);

        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                health[i]       <= game_pkg::METEOR_START_HP;
                meteor_alive[i] <= 1'b1;
            end else if (restart) begin
                health[i]       <= game_pkg::METEOR_START_HP;
                meteor_alive[i] <= 1'b1;
            end else if (play_tick && hit_sel[i]) begin
                health[i] <= health[i] - 1'b1;
                if (health[i] == game_pkg::hp_t'(1))
                    meteor_alive[i] <= 1'b0;
            end
        end

        // a meteor dies exactly when its last hit point is gone, and takes no hit after that
        assert property (@(posedge clk) disable iff (!reset_n)
            !meteor_alive[i] |-> (health[i] == '0))
            else $error("dead meteor %0d still has hit points", i);
    end

    // only the lowest numbered overlapping meteor takes the hit
    assign hit_sel      = hit_vec & (~hit_vec + 1'b1);
    assign bullet_hit   = |hit_vec;
    assign ship_contact = |contact_vec;

    always_comb begin
        kill_points = '0;
        for (int i = 0; i < NUM_METEORS; i++) begin
            if (hit_sel[i] && (health[i] == game_pkg::hp_t'(1)))
                kill_points = game_pkg::meteor_points(meteors[i].size);
        end
    end

endmodule

`default_nettype wire

//--- hdl/score_health_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module score_health_tracker #(
    parameter int INVINC_FRAMES = 60
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              frame_tick,
    input  logic              play_tick,
    input  logic              restart,
    input  game_pkg::points_t kill_points,
    input  logic              ship_contact,
    output game_pkg::score_t  score,
    output game_pkg::hp_t     ship_hp,
    output logic              hull_depleted
);

    game_pkg::frame_count_t invinc_timer;
    logic                   take_hit;

    // contact only counts once the invincibility window has run out
    assign take_hit = play_tick && ship_contact && (invinc_timer == '0) && (ship_hp != '0);

    assign hull_depleted = take_hit && (ship_hp == game_pkg::hp_t'(1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            score        <= '0;
            ship_hp      <= game_pkg::SHIP_MAX_HP;
            invinc_timer <= '0;
        end else if (restart) begin
            score        <= '0;
            ship_hp      <= game_pkg::SHIP_MAX_HP;
            invinc_timer <= '0;
        end else if (frame_tick) begin
            if (invinc_timer != '0)
                invinc_timer <= invinc_timer - 1'b1;
            if (play_tick)
                score <= score + game_pkg::score_t'(kill_points);
            if (take_hit) begin
                ship_hp      <= ship_hp - 1'b1;
                invinc_timer <= game_pkg::frame_count_t'(INVINC_FRAMES);
            end
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        ship_hp <= game_pkg::SHIP_MAX_HP)
        else $error("ship_hp above its maximum");

    // the frame that takes the last point leaves the hull empty
    assert property (@(posedge clk) disable iff (!reset_n)
        hull_depleted |=> (ship_hp == '0))
        else $error("hull_depleted without ship_hp reaching zero");

endmodule

`default_nettype wire

//--- hdl/game_core.sv
`timescale 1ns/100ps
`default_nettype none

module game_core #(
    parameter int NUM_METEORS   = 5,
    parameter int FIRE_COOLDOWN = 30,
    parameter int INVINC_FRAMES = 60
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   frame_tick,
    input  logic                   btn_up,
    input  logic                   btn_down,
    input  logic                   btn_left,
    input  logic                   btn_right,
    input  logic                   btn_fire,
    input  logic                   btn_restart,
    input  game_pkg::meteor_t      meteors [NUM_METEORS],
    output game_pkg::coord_t       ship_x,
    output game_pkg::coord_t       ship_y,
    output game_pkg::facing_t      ship_facing,
    output game_pkg::coord_t       bullet_x,
    output game_pkg::coord_t       bullet_y,
    output logic                   bullet_active,
    output logic [NUM_METEORS-1:0] meteor_alive,
    output game_pkg::score_t       score,
    output game_pkg::hp_t          ship_hp,
    output logic                   game_over
);

    logic                play_tick;
    logic                restart;
    game_pkg::move_cmd_t cmd;
    logic                hull_depleted;
    logic                bullet_hit;
    logic                ship_contact;
    game_pkg::points_t   kill_points;

    input_decode input_decode_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .frame_tick    (frame_tick),
        .btn_up        (btn_up),
        .btn_down      (btn_down),
        .btn_left      (btn_left),
        .btn_right     (btn_right),
        .btn_fire      (btn_fire),
        .btn_restart   (btn_restart),
        .hull_depleted (hull_depleted),
        .play_tick     (play_tick),
        .restart       (restart),
        .cmd           (cmd),
        .game_over     (game_over)
    );

    ship_bullet_motion #(
        .FIRE_COOLDOWN (FIRE_COOLDOWN)
    ) ship_bullet_motion_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .frame_tick    (frame_tick),
        .play_tick     (play_tick),
        .restart       (restart),
        .cmd           (cmd),
        .bullet_hit    (bullet_hit),
        .ship_x        (ship_x),
        .ship_y        (ship_y),
        .ship_facing   (ship_facing),
        .bullet_x      (bullet_x),
        .bullet_y      (bullet_y),
        .bullet_active (bullet_active)
    );

    meteor_hit_check #(
        .NUM_METEORS (NUM_METEORS)
    ) meteor_hit_check_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .play_tick     (play_tick),
        .restart       (restart),
        .meteors       (meteors),
        .ship_x        (ship_x),
        .ship_y        (ship_y),
        .bullet_x      (bullet_x),
        .bullet_y      (bullet_y),
        .bullet_active (bullet_active),
        .meteor_alive  (meteor_alive),
        .bullet_hit    (bullet_hit),
        .ship_contact  (ship_contact),
        .kill_points   (kill_points)
    );

    score_health_tracker #(
        .INVINC_FRAMES (INVINC_FRAMES)
    ) score_health_tracker_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .frame_tick    (frame_tick),
        .play_tick     (play_tick),
        .restart       (restart),
        .kill_points   (kill_points),
        .ship_contact  (ship_contact),
        .score         (score),
        .ship_hp       (ship_hp),
        .hull_depleted (hull_depleted)
    );

endmodule

`default_nettype wire

//--- tb/game_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module game_core_tb;

    localparam int NUM_METEORS      = 5;
    localparam int FIRE_COOLDOWN    = 30;
    localparam int INVINC_FRAMES    = 60;
    localparam int NUM_FRAMES       = 2400;
    localparam int PHASE_FRAMES     = 300;
    localparam int RESET_WAIT_LIMIT = 40;
    localparam int TICK_WAIT_LIMIT  = 20;
    localparam int SHIP_STEP        = 2;
    localparam int BULLET_STEP      = 10;
    localparam int SHIP_RADIUS      = 10;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic fire;
        logic restart;
    } buttons_t;

    typedef game_pkg::meteor_t [NUM_METEORS-1:0] meteor_pack_t;

    // everything the game remembers from one frame to the next
    typedef struct packed {
        game_pkg::coord_t                ship_x;
        game_pkg::coord_t                ship_y;
        game_pkg::facing_t               facing;
        game_pkg::coord_t                bullet_x;
        game_pkg::coord_t                bullet_y;
        logic                            bullet_active;
        game_pkg::frame_count_t          cooldown;
        game_pkg::hp_t [NUM_METEORS-1:0] health;
        logic [NUM_METEORS-1:0]          alive;
        game_pkg::score_t                score;
        game_pkg::hp_t                   hp;
        game_pkg::frame_count_t          invinc;
        logic                            over;
    } model_t;

    logic                   clk;
    logic                   reset_n;
    logic                   frame_tick;
    buttons_t               btns;
    game_pkg::meteor_t      meteors [NUM_METEORS];
    game_pkg::coord_t       ship_x;
    game_pkg::coord_t       ship_y;
    game_pkg::facing_t      ship_facing;
    game_pkg::coord_t       bullet_x;
    game_pkg::coord_t       bullet_y;
    logic                   bullet_active;
    logic [NUM_METEORS-1:0] meteor_alive;
    game_pkg::score_t       score;
    game_pkg::hp_t          ship_hp;
    logic                   game_over;

    model_t      model;
    logic [15:0] lfsr_state;

    game_core game_core_inst (
        .clk           (clk),
        .reset_n       (reset_n),
        .frame_tick    (frame_tick),
        .btn_up        (btns.up),
        .btn_down      (btns.down),
        .btn_left      (btns.left),
        .btn_right     (btns.right),
        .btn_fire      (btns.fire),
        .btn_restart   (btns.restart),
        .meteors       (meteors),
        .ship_x        (ship_x),
        .ship_y        (ship_y),
        .ship_facing   (ship_facing),
        .bullet_x      (bullet_x),
        .bullet_y      (bullet_y),
        .bullet_active (bullet_active),
        .meteor_alive  (meteor_alive),
        .score         (score),
        .ship_hp       (ship_hp),
        .game_over     (game_over)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    function automatic int manhattan(input game_pkg::coord_t x, input game_pkg::coord_t y,
                                     input game_pkg::meteor_t mt);
        int dx;
        int dy;
        dx = int'(x) - int'(mt.x);
        dy = int'(y) - int'(mt.y);
        return ((dx < 0) ? -dx : dx) + ((dy < 0) ? -dy : dy);
    endfunction

    function automatic model_t start_state();
        model_t n;
        n = '0;
        n.ship_x = 10'd320;
        n.ship_y = 10'd240;
        n.facing = game_pkg::FACE_UP;
        for (int i = 0; i < NUM_METEORS; i++)
            n.health[i] = 3'd3;
        n.alive = '1;
        n.hp    = 3'd4;
        return n;
    endfunction

    function automatic model_t apply_frame(input model_t s, input buttons_t b,
                                           input meteor_pack_t m);
        model_t n;
        int     sz;
        int     rad;
        int     hit_idx;
        int     hit_pts;
        int     nx;
        int     ny;
        int     by;
        logic   contact;
        logic   launch;
        logic   hurt;
        n = s;
        if (s.over) begin
            if (b.restart)
                return start_state();
            if (s.cooldown != '0)
                n.cooldown = s.cooldown - 8'd1;
            if (s.invinc != '0)
                n.invinc = s.invinc - 8'd1;
            return n;
        end
        // walk downwards so the lowest numbered overlap is the one left standing
        hit_idx = -1;
        hit_pts = 0;
        contact = 1'b0;
        for (int i = NUM_METEORS - 1; i >= 0; i--) begin
            sz  = (m[i].size > 3'd4) ? 4 : int'(m[i].size);
            rad = 4 + 4 * sz;
            if (s.alive[i] && s.bullet_active &&
                manhattan(s.bullet_x, s.bullet_y, m[i]) <= rad) begin
                hit_idx = i;
                hit_pts = 10 * (sz + 1);
            end
            if (s.alive[i] && manhattan(s.ship_x, s.ship_y, m[i]) <= SHIP_RADIUS + rad)
                contact = 1'b1;
        end
        nx = int'(s.ship_x);
        ny = int'(s.ship_y);
        if (b.up) begin
            ny = (ny - SHIP_STEP < 0) ? 0 : ny - SHIP_STEP;
            n.facing = game_pkg::FACE_UP;
        end else if (b.down) begin
            ny = (ny + SHIP_STEP > 479) ? 479 : ny + SHIP_STEP;
            n.facing = game_pkg::FACE_DOWN;
        end else if (b.right) begin
            nx = (nx + SHIP_STEP > 639) ? 639 : nx + SHIP_STEP;
            n.facing = game_pkg::FACE_RIGHT;
        end else if (b.left) begin
            nx = (nx - SHIP_STEP < 0) ? 0 : nx - SHIP_STEP;
            n.facing = game_pkg::FACE_LEFT;
        end
        n.ship_x = game_pkg::coord_t'(nx);
        n.ship_y = game_pkg::coord_t'(ny);
        launch = b.fire && !s.bullet_active && (s.cooldown == '0);
        if (s.cooldown != '0)
            n.cooldown = s.cooldown - 8'd1;
        if (launch) begin
            n.cooldown      = game_pkg::frame_count_t'(FIRE_COOLDOWN);
            n.bullet_active = 1'b1;
            n.bullet_x      = s.ship_x;   // leaves from where the ship stood
            n.bullet_y      = s.ship_y;
        end else if (s.bullet_active) begin
            by = int'(s.bullet_y) - BULLET_STEP;
            if (by <= 0) begin
                by = 0;
                n.bullet_active = 1'b0;
            end
            n.bullet_y = game_pkg::coord_t'(by);
            if (hit_idx >= 0)
                n.bullet_active = 1'b0;
        end
        if (hit_idx >= 0) begin
            n.health[hit_idx] = s.health[hit_idx] - 3'd1;
            if (s.health[hit_idx] == 3'd1) begin
                n.alive[hit_idx] = 1'b0;
                n.score = s.score + game_pkg::score_t'(hit_pts);
            end
        end
        hurt = contact && (s.invinc == '0) && (s.hp != '0);
        if (s.invinc != '0)
            n.invinc = s.invinc - 8'd1;
        if (hurt) begin
            n.hp     = s.hp - 3'd1;
            n.invinc = game_pkg::frame_count_t'(INVINC_FRAMES);
            n.over   = (s.hp == 3'd1);
        end
        return n;
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s at time %0t", why, $time);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_coord(input string name, input game_pkg::coord_t act,
                               input game_pkg::coord_t exp);
        if (act !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, act, exp);
            stop_on_failure("an output did not match the model");
        end
    endtask

    task automatic check_score(input string name, input game_pkg::score_t act,
                               input game_pkg::score_t exp);
        if (act !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, act, exp);
            stop_on_failure("an output did not match the model");
        end
    endtask

    task automatic check_hp(input string name, input game_pkg::hp_t act,
                            input game_pkg::hp_t exp);
        if (act !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, act, exp);
            stop_on_failure("an output did not match the model");
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, act, exp);
            stop_on_failure("an output did not match the model");
        end
    endtask

    task automatic check_facing(input string name, input game_pkg::facing_t act,
                                input game_pkg::facing_t exp);
        if (act !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, act, exp);
            stop_on_failure("an output did not match the model");
        end
    endtask

    task automatic compare_outputs();
        check_coord("ship_x", ship_x, model.ship_x);
        check_coord("ship_y", ship_y, model.ship_y);
        check_facing("ship_facing", ship_facing, model.facing);
        check_flag("bullet_active", bullet_active, model.bullet_active);
        check_coord("bullet_x", bullet_x, model.bullet_x);
        check_coord("bullet_y", bullet_y, model.bullet_y);
        for (int i = 0; i < NUM_METEORS; i++)
            check_flag($sformatf("meteor_alive[%0d]", i), meteor_alive[i], model.alive[i]);
        check_score("score", score, model.score);
        check_hp("ship_hp", ship_hp, model.hp);
        check_flag("game_over", game_over, model.over);
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < RESET_WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (reset_n !== 1'b1)
            stop_on_failure("reset_n was never released");
    endtask

    // returns on the edge at which the DUT samples frame_tick high
    task automatic wait_for_tick();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (frame_tick !== 1'b1 && cycles < TICK_WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (frame_tick !== 1'b1)
            stop_on_failure("no frame_tick arrived in time");
    endtask

    task automatic drive_frame(input int k, input int over_frames);
        buttons_t          b;
        game_pkg::meteor_t m;
        logic [15:0]       r;
        int                dir;
        logic              hunt;
        logic              bullet_far;
        dir        = (k / PHASE_FRAMES) % 4;
        hunt       = ((k % PHASE_FRAMES) >= 2 * PHASE_FRAMES / 3);   // meteors chase the ship
        bullet_far = model.bullet_active && (int'(model.bullet_y) + 60 < int'(model.ship_y));
        b = '0;
        take_bits(4, r);
        {b.up, b.down, b.right, b.left} = r[3:0];
        take_bits(2, r);
        if (r[1:0] != 2'b00) begin
            case (dir)
                0:       {b.up, b.down, b.right, b.left} = 4'b1000;
                1:       {b.up, b.down, b.right, b.left} = 4'b0010;
                2:       {b.up, b.down, b.right, b.left} = 4'b0100;
                default: {b.up, b.down, b.right, b.left} = 4'b0001;
            endcase
        end
        take_bits(1, r);
        b.fire     = r[0];
        b.restart  = model.over && (over_frames >= 3);
        btns       <= b;
        frame_tick <= 1'b1;
        for (int i = 0; i < NUM_METEORS; i++) begin
            take_bits(15, r);
            m.size = r[2:0];
            if (hunt && r[4:3] == 2'b11) begin
                m.x = game_pkg::coord_t'(int'(model.ship_x) + int'(r[9:5]) - 16);
                m.y = game_pkg::coord_t'(int'(model.ship_y) + int'(r[14:10]) - 16);
            end else if (bullet_far && r[4:3] != 2'b00) begin
                m.x = game_pkg::coord_t'(int'(model.bullet_x) + int'(r[9:5]) - 16);
                m.y = game_pkg::coord_t'(int'(model.bullet_y) + int'(r[14:10]) - 16);
            end else begin
                m.x = game_pkg::coord_t'(768 + 8 * int'(r[9:5]));   // parked right of the screen
                m.y = game_pkg::coord_t'(16 * int'(r[14:10]));
            end
            meteors[i] <= m;
        end
    endtask

    initial begin : drive_proc
        int over_frames;
        reset_n     = 1'b0;
        frame_tick  = 1'b0;
        btns        = '0;
        lfsr_state  = 16'd80;
        over_frames = 0;
        for (int i = 0; i < NUM_METEORS; i++)
            meteors[i] = '{x: 10'd1000, y: 10'd0, size: 3'd0};
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        repeat (4) @(posedge clk);
        for (int k = 0; k < NUM_FRAMES; k++) begin
            @(posedge clk);
            over_frames = model.over ? over_frames + 1 : 0;
            drive_frame(k, over_frames);
            @(posedge clk);
            frame_tick <= 1'b0;
            repeat (2) @(posedge clk);
        end
    end

    initial begin : check_proc
        meteor_pack_t met_pk;
        buttons_t     b;
        model = start_state();
        wait_reset_release();
        @(negedge clk);
        compare_outputs();
        for (int k = 0; k < NUM_FRAMES; k++) begin
            wait_for_tick();
            b = btns;
            for (int i = 0; i < NUM_METEORS; i++)
                met_pk[i] = meteors[i];
            model = apply_frame(model, b, met_pk);
            @(negedge clk);   // outputs have settled one clock after the tick
            compare_outputs();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/game_pkg.sv
hdl/input_decode.sv
hdl/ship_bullet_motion.sv
hdl/meteor_hit_check.sv
hdl/score_health_tracker.sv
hdl/game_core.sv
tb/game_core_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module game_core_tb \
    -f all.f -o game_core_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/game_core_sim > sim.log 2>&1
cat sim.log
grep -q "SIMULATION PASSED" sim.log && echo "run ok" || { echo "run failed"; exit 1; }
